/* rtl/clap_macros.svh */
/*
 * Line geometry, AXI widths and valid address range
 * for the clap cache line store
 */
`ifndef CLAP_MACROS_SVH
`define CLAP_MACROS_SVH

// Line geometry
`define CLAP_NB_COL      64    // Bytes per line
`define CLAP_COL_WIDTH   8     // Bits per byte column
`define CLAP_RAM_DEPTH   64    // Lines in the store

// AXI4-Lite port
`define CLAP_AXI_AW      32
`define CLAP_AXI_DW      32

// First byte address past the store, 64 lines x 64 bytes
`define CLAP_ADDR_LIMIT  4096

// Derived sizes
`define CLAP_LINE_W      (`CLAP_NB_COL * `CLAP_COL_WIDTH)
`define CLAP_WORDS       (`CLAP_LINE_W / `CLAP_AXI_DW)

`endif

/* rtl/clap_pkg.sv */
/*
 * Shared types of the cache line store:
 * index types, request structs, R response struct, response code
 */
`include "clap_macros.svh"

package clap_pkg;

  typedef logic [$clog2(`CLAP_RAM_DEPTH)-1:0] line_idx_t;  // Line number
  typedef logic [$clog2(`CLAP_WORDS)-1:0]     word_idx_t;  // Word within a line
  typedef logic [`CLAP_LINE_W-1:0]            line_t;      // Whole line

  // AXI response code, only the two used here
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // Write request, data already copied into every word slot
  typedef struct packed {
    line_idx_t                line;
    line_t                    data;
    logic [`CLAP_NB_COL-1:0]  be;    // Byte enables, zero on error
    logic                     err;   // Address out of range
  } wr_req_t;

  // Read request
  typedef struct packed {
    line_idx_t  line;
    word_idx_t  word;
    logic       err;
  } rd_req_t;

  // R channel payload
  typedef struct packed {
    logic [`CLAP_AXI_DW-1:0]  data;
    resp_e                    resp;
  } r_rsp_t;

endpackage

/* rtl/req_slice.sv */
/*
 * One-deep register slice, payload type as parameter,
 * valid for one cycle after each load
 */
`timescale 1ns/100ps

module req_slice #(
  parameter type payload_t = logic
) (
  input  logic     clka,
  input  logic     rst_n,
  input  logic     load,   // Capture strobe
  input  payload_t din,
  output logic     valid,  // One-cycle issue slot
  output payload_t dout
);

  payload_t data_q;

  // Issue slot follows the load by one cycle
  // Payload stays after valid drops, RAM ports keep a stable address
  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      valid  <= 1'b0;
      data_q <= '0;  // RAM ports see line 0 until the first load
    end else begin
      valid <= load;
      if (load) begin
        data_q <= din;
      end
    end
  end

  assign dout = data_q;

endmodule

/* rtl/cache_memory.sv */
/*
 * True dual-port byte-write line RAM, write-first,
 * one-cycle read latency with same-line forwarding
 */
`timescale 1ns/100ps
`include "clap_macros.svh"

module cache_memory
  import clap_pkg::*;
#(
  parameter int NB_COL    = `CLAP_NB_COL,     // Byte columns per line
  parameter int COL_WIDTH = `CLAP_COL_WIDTH,  // Bits per column
  parameter int RAM_DEPTH = `CLAP_RAM_DEPTH   // Lines
) (
  input  logic              clka,
  input  logic              ena,    // Port a write slot
  input  logic [NB_COL-1:0] wea,    // Byte enables
  input  line_idx_t         addra,  // Write line
  input  line_idx_t         addrb,  // Read line
  input  line_t             dina,
  output line_t             doutb
);

  logic [NB_COL*COL_WIDTH-1:0] mem [RAM_DEPTH];
  logic [NB_COL*COL_WIDTH-1:0] ram_data_a;  // Port a line after this cycle's write
  logic [NB_COL*COL_WIDTH-1:0] ram_data_b;  // Port b line, old contents
  logic                        last_addr_eq;

  // Store starts cleared
  initial begin
    for (int r = 0; r < RAM_DEPTH; r++) begin
      mem[r] = '0;
    end
  end

  // Port a, column writes
  always @(posedge clka) begin
    for (int i = 0; i < NB_COL; i++) begin
      if (ena && wea[i]) begin
        mem[addra][i*COL_WIDTH +: COL_WIDTH]  <= dina[i*COL_WIDTH +: COL_WIDTH];
        ram_data_a[i*COL_WIDTH +: COL_WIDTH] <= dina[i*COL_WIDTH +: COL_WIDTH];  // New byte
      end else begin
        ram_data_a[i*COL_WIDTH +: COL_WIDTH] <= mem[addra][i*COL_WIDTH +: COL_WIDTH];
      end
    end
  end

  // Port b read, sees contents before this edge
  always_ff @(posedge clka) begin
    ram_data_b <= mem[addrb];
  end

  // Collision flag for next cycle's output mux
  always_ff @(posedge clka) begin
    last_addr_eq <= (addra == addrb);
  end

  // Same line on both ports, port a copy holds the merged bytes
  assign doutb = last_addr_eq ? ram_data_a : ram_data_b;

endmodule

/* rtl/axil_req_decode.sv */
/*
 * AXI4-Lite AW/W/AR acceptance, independent AW and W holding,
 * address range check and line/word/strobe decode
 */
`timescale 1ns/100ps
`include "clap_macros.svh"

module axil_req_decode
  import clap_pkg::*;
(
  input  logic                      clka,
  input  logic                      rst_n,
  input  logic [`CLAP_AXI_AW-1:0]   awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [`CLAP_AXI_DW-1:0]   wdata,
  input  logic [`CLAP_AXI_DW/8-1:0] wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  input  logic [`CLAP_AXI_AW-1:0]   araddr,
  input  logic                      arvalid,
  output logic                      arready,
  input  logic                      wr_busy,  // Write in flight until B
  input  logic                      rd_busy,  // Read in flight until R
  output logic                      wr_load,
  output logic                      rd_load,
  output wr_req_t                   wr_req,
  output rd_req_t                   rd_req
);

  localparam int STRB_W   = `CLAP_AXI_DW / 8;
  localparam int WORD_LSB = $clog2(STRB_W);
  localparam int LINE_LSB = $clog2(`CLAP_NB_COL);

  logic                    run_q;     // Out of reset
  logic                    aw_held_q;
  logic                    w_held_q;
  logic [`CLAP_AXI_AW-1:0] aw_addr_q;
  logic [`CLAP_AXI_DW-1:0] w_data_q;
  logic [STRB_W-1:0]       w_strb_q;
  logic                    aw_fire;
  logic                    w_fire;
  logic [`CLAP_AXI_AW-1:0] wr_addr;
  logic [`CLAP_AXI_DW-1:0] wr_data;
  logic [STRB_W-1:0]       wr_strb;

  // Each channel blocks once its half is held or a write is outstanding
  assign awready = run_q && !aw_held_q && !wr_busy;
  assign wready  = run_q && !w_held_q && !wr_busy;
  assign arready = run_q && !rd_busy;

  assign aw_fire = awvalid && awready;
  assign w_fire  = wvalid && wready;

  // Issue in the cycle the later half arrives
  assign wr_load = (aw_held_q || aw_fire) && (w_held_q || w_fire);
  assign rd_load = arvalid && arready;

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      run_q     <= 1'b0;
      aw_held_q <= 1'b0;
      w_held_q  <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (wr_load) begin
        aw_held_q <= 1'b0;  // Both halves consumed
        w_held_q  <= 1'b0;
      end else begin
        if (aw_fire) aw_held_q <= 1'b1;
        if (w_fire)  w_held_q  <= 1'b1;
      end
    end
  end

  // Early half parked here
  always_ff @(posedge clka) begin
    if (aw_fire) aw_addr_q <= awaddr;
    if (w_fire) begin
      w_data_q <= wdata;
      w_strb_q <= wstrb;
    end
  end

  assign wr_addr = aw_held_q ? aw_addr_q : awaddr;
  assign wr_data = w_held_q ? w_data_q : wdata;
  assign wr_strb = w_held_q ? w_strb_q : wstrb;

  // Write decode
  always_comb begin
    wr_req      = '0;
    wr_req.err  = (wr_addr >= `CLAP_ADDR_LIMIT);
    wr_req.line = wr_addr[LINE_LSB +: $bits(line_idx_t)];
    wr_req.data = {`CLAP_WORDS{wr_data}};  // Same word in every slot
    if (!wr_req.err) begin
      wr_req.be[int'(wr_addr[WORD_LSB +: $bits(word_idx_t)]) * STRB_W +: STRB_W] = wr_strb;
    end
  end

  // Read decode
  always_comb begin
    rd_req.err  = (araddr >= `CLAP_ADDR_LIMIT);
    rd_req.line = araddr[LINE_LSB +: $bits(line_idx_t)];
    rd_req.word = araddr[WORD_LSB +: $bits(word_idx_t)];
  end

endmodule

/* rtl/line_result.sv */
/*
 * Word select from the read line, B and R response
 * registers held under back-pressure, busy flags
 */
`timescale 1ns/100ps
`include "clap_macros.svh"

module line_result
  import clap_pkg::*;
(
  input  logic                    clka,
  input  logic                    rst_n,
  input  logic                    wr_load,   // Write accepted
  input  logic                    rd_load,   // Read accepted
  input  logic                    wr_valid,  // Write in RAM this cycle
  input  logic                    rd_valid,  // Read address at RAM this cycle
  input  logic                    wr_err,
  input  rd_req_t                 rd_req,
  input  line_t                   doutb,
  output logic                    bvalid,
  output resp_e                   bresp,
  input  logic                    bready,
  output logic                    rvalid,
  output logic [`CLAP_AXI_DW-1:0] rdata,
  output resp_e                   rresp,
  input  logic                    rready,
  output logic                    wr_busy,
  output logic                    rd_busy
);

  logic      rd_pend_q;  // doutb valid this cycle
  logic      r_hold_q;   // R stalled, serve from r_rsp_q
  word_idx_t rd_word_q;
  logic      rd_err_q;
  r_rsp_t    r_live;
  r_rsp_t    r_rsp_q;
  r_rsp_t    r_out;

  // Word and error lined up with doutb
  always_ff @(posedge clka) begin
    rd_word_q <= rd_req.word;
    rd_err_q  <= rd_req.err;
    if (rd_pend_q) r_rsp_q <= r_live;  // Copy for a stalled R
  end

  always_comb begin
    r_live.data = rd_err_q ? '0 : doutb[int'(rd_word_q) * `CLAP_AXI_DW +: `CLAP_AXI_DW];
    r_live.resp = rd_err_q ? RESP_SLVERR : RESP_OKAY;
  end

  assign r_out  = rd_pend_q ? r_live : r_rsp_q;
  assign rvalid = rd_pend_q || r_hold_q;
  assign rdata  = r_out.data;
  assign rresp  = r_out.resp;

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      rd_pend_q <= 1'b0;
      r_hold_q  <= 1'b0;
      bvalid    <= 1'b0;
      bresp     <= RESP_OKAY;
      wr_busy   <= 1'b0;
      rd_busy   <= 1'b0;
    end else begin
      rd_pend_q <= rd_valid;
      if (rvalid && rready) r_hold_q <= 1'b0;
      else if (rd_pend_q)   r_hold_q <= 1'b1;  // Not taken in first cycle
      // B one cycle after the RAM write
      if (wr_valid) begin
        bvalid <= 1'b1;
        bresp  <= wr_err ? RESP_SLVERR : RESP_OKAY;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      // Busy from acceptance until the response leaves
      if (wr_load)                wr_busy <= 1'b1;
      else if (bvalid && bready)  wr_busy <= 1'b0;
      if (rd_load)                rd_busy <= 1'b1;
      else if (rvalid && rready)  rd_busy <= 1'b0;
    end
  end

endmodule

/* rtl/cache_line_store.sv */
/*
 * Cache line store top, AXI4-Lite slave over a
 * 64 x 64-byte byte-write line RAM
 */
`timescale 1ns/100ps
`include "clap_macros.svh"

module cache_line_store
  import clap_pkg::*;
(
  input  logic                      clka,
  input  logic                      rst_n,
  input  logic [`CLAP_AXI_AW-1:0]   awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [`CLAP_AXI_DW-1:0]   wdata,
  input  logic [`CLAP_AXI_DW/8-1:0] wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  output resp_e                     bresp,
  output logic                      bvalid,
  input  logic                      bready,
  input  logic [`CLAP_AXI_AW-1:0]   araddr,
  input  logic                      arvalid,
  output logic                      arready,
  output logic [`CLAP_AXI_DW-1:0]   rdata,
  output resp_e                     rresp,
  output logic                      rvalid,
  input  logic                      rready
);

  logic    wr_load, rd_load;
  logic    wr_valid, rd_valid;
  logic    wr_busy, rd_busy;
  wr_req_t wr_req_d, wr_req_q;  // Decoded, then sliced
  rd_req_t rd_req_d, rd_req_q;
  line_t   doutb;

  axil_req_decode decode_i (
    .clka, .rst_n,
    .awaddr, .awvalid, .awready,
    .wdata, .wstrb, .wvalid, .wready,
    .araddr, .arvalid, .arready,
    .wr_busy, .rd_busy,
    .wr_load, .rd_load,
    .wr_req (wr_req_d),
    .rd_req (rd_req_d)
  );

  req_slice #(.payload_t(wr_req_t)) wr_slice_i (
    .clka, .rst_n,
    .load  (wr_load),
    .din   (wr_req_d),
    .valid (wr_valid),
    .dout  (wr_req_q)
  );

  req_slice #(.payload_t(rd_req_t)) rd_slice_i (
    .clka, .rst_n,
    .load  (rd_load),
    .din   (rd_req_d),
    .valid (rd_valid),
    .dout  (rd_req_q)
  );

  cache_memory mem_i (
    .clka,
    .ena   (wr_valid),
    .wea   (wr_req_q.be),     // Zero for an out-of-range write
    .addra (wr_req_q.line),
    .addrb (rd_req_q.line),
    .dina  (wr_req_q.data),
    .doutb
  );

  line_result result_i (
    .clka, .rst_n,
    .wr_load, .rd_load, .wr_valid, .rd_valid,
    .wr_err (wr_req_q.err),
    .rd_req (rd_req_q),
    .doutb,
    .bvalid, .bresp, .bready,
    .rvalid, .rdata, .rresp, .rready,
    .wr_busy, .rd_busy
  );

endmodule

/* sim/tb_clock.sv */
/*
 * Testbench clock and reset, 4 ns period,
 * reset held low for the first two cycles
 */
`timescale 1ns/100ps

module tb_clock #(
  parameter int PERIOD_NS  = 4,
  parameter int RST_CYCLES = 2
) (
  output logic clka,
  output logic rst_n
);

  initial begin
    clka = 1'b0;
    forever #(PERIOD_NS / 2.0) clka = ~clka;
  end

  // Release on a falling edge, clear of the active edge
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clka);
    @(negedge clka);
    rst_n = 1'b1;
  end

endmodule

/* sim/cache_line_store_chk.sv */
/*
 * AXI4-Lite handshake assertions for the cache line store,
 * bound into the top level
 */
`timescale 1ns/100ps
`include "clap_macros.svh"

module cache_line_store_chk (
  input logic                    clka,
  input logic                    rst_n,
  input logic [`CLAP_AXI_AW-1:0] awaddr,
  input logic                    awvalid,
  input logic                    awready,
  input logic [1:0]              bresp,
  input logic                    bvalid,
  input logic                    bready,
  input logic [`CLAP_AXI_AW-1:0] araddr,
  input logic                    arvalid,
  input logic                    arready,
  input logic [`CLAP_AXI_DW-1:0] rdata,
  input logic [1:0]              rresp,
  input logic                    rvalid,
  input logic                    rready
);

  int unsigned fail_cnt = 0;  // Failed assertions so far

  function automatic void note_failure(input string msg);
    $error("%s", msg);
    fail_cnt++;
  endfunction

  // Responses hold with a stable payload until taken
  b_keep: assert property (@(posedge clka) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else note_failure("BVALID or BRESP changed before BREADY");
  r_keep: assert property (@(posedge clka) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else note_failure("RVALID, RDATA or RRESP changed before RREADY");

  // Host side requests
  aw_keep: assert property (@(posedge clka) disable iff (!rst_n)
    awvalid && !awready |=> awvalid && $stable(awaddr))
    else note_failure("AWVALID or AWADDR changed before AWREADY");
  ar_keep: assert property (@(posedge clka) disable iff (!rst_n)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else note_failure("ARVALID or ARADDR changed before ARREADY");

  // One read outstanding
  ar_block: assert property (@(posedge clka) disable iff (!rst_n)
    rvalid |-> !arready)
    else note_failure("ARREADY high while RVALID is pending");

  // Sampled between edges so async reset has settled
  reset_quiet: assert property (@(negedge clka)
    !rst_n |-> !bvalid && !rvalid && !awready && !arready)
    else note_failure("Handshake signal high during reset");

endmodule

bind cache_line_store cache_line_store_chk chk_i (.*);

/* sim/cache_line_store_tb.sv */
/*
 * Table-driven testbench for the cache line store: AXI4-Lite driver,
 * byte-array reference model, LFSR data and watchdog
 */
`timescale 1ns/100ps
`include "clap_macros.svh"

module cache_line_store_tb
  import clap_pkg::*;
();

  localparam int CLK_NS   = 4;
  localparam int MAX_ROWS = 32;
  localparam int LIMIT    = `CLAP_ADDR_LIMIT;

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_WR_RD} op_e;
  typedef enum logic [1:0] {AW_THEN_W, W_THEN_AW, AW_WITH_W} order_e;

  typedef struct packed {
    op_e         op;
    logic [31:0] addr;
    logic [31:0] data;
    logic        rnd;    // Data from the LFSR
    logic [3:0]  strb;
    order_e      order;
    logic [3:0]  hold;   // Cycles with BREADY/RREADY low
    resp_e       resp;   // Expected B/R code
  } entry_t;

  logic        clka, rst_n;
  logic [31:0] awaddr, wdata, araddr, rdata;
  logic [3:0]  wstrb;
  logic        awvalid, awready, wvalid, wready, bvalid, bready;
  logic        arvalid, arready, rvalid, rready;
  resp_e       bresp, rresp;

  entry_t      rows [MAX_ROWS];
  int          n_rows     = 0;
  logic        rows_ready = 1'b0;
  logic [15:0] lfsr       = 16'd17614;
  logic [7:0]  model [LIMIT];  // Byte image of the store

  tb_clock #(.PERIOD_NS(CLK_NS), .RST_CYCLES(2)) clk_i (.clka, .rst_n);

  cache_line_store dut_i (.*);

  // Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    for (int i = 0; i < 32; i++) begin
      w[i] = lfsr[0];  // One step per bit
      lfsr = lfsr_next(lfsr);
    end
    return w;
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("MISMATCH at time %0d ns: %s expected %h actual %h", $time, name, exp, act);
      $display("Testbench failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic update_model(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
    int base;
    if (addr >= LIMIT) return;  // SLVERR, store untouched
    base = int'({addr[11:2], 2'b00});
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) model[base + b] = data[8*b +: 8];
    end
  endtask

  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    int base;
    if (addr >= LIMIT) return '0;
    base = int'({addr[11:2], 2'b00});
    return {model[base + 3], model[base + 2], model[base + 1], model[base]};
  endfunction

  // Valid goes up on a falling edge, ready checked there, dropped after the transfer
  task automatic aw_phase(input logic [31:0] addr);
    @(negedge clka);
    awaddr  = addr;
    awvalid = 1'b1;
    while (!awready) @(negedge clka);
    @(negedge clka);
    awvalid = 1'b0;
  endtask

  task automatic w_phase(input logic [31:0] data, input logic [3:0] strb);
    @(negedge clka);
    wdata  = data;
    wstrb  = strb;
    wvalid = 1'b1;
    while (!wready) @(negedge clka);
    @(negedge clka);
    wvalid = 1'b0;
  endtask

  task automatic ar_phase(input logic [31:0] addr);
    @(negedge clka);
    araddr  = addr;
    arvalid = 1'b1;
    while (!arready) @(negedge clka);
    @(negedge clka);
    arvalid = 1'b0;
  endtask

  task automatic b_response(input logic [3:0] hold, input resp_e exp);
    while (!bvalid) @(negedge clka);
    compare("bresp", exp, bresp);
    repeat (hold) begin
      @(negedge clka);
      compare("bvalid", 1, bvalid);
      compare("bresp", exp, bresp);
      compare("awready", 0, awready);  // Write path closed
      compare("wready", 0, wready);
    end
    bready = 1'b1;
    @(negedge clka);
    bready = 1'b0;
  endtask

  task automatic r_response(input logic [3:0] hold, input logic [31:0] exp_data,
                            input resp_e exp);
    while (!rvalid) @(negedge clka);
    compare("rdata", exp_data, rdata);
    compare("rresp", exp, rresp);
    repeat (hold) begin
      @(negedge clka);
      compare("rvalid", 1, rvalid);
      compare("rdata", exp_data, rdata);
      compare("rresp", exp, rresp);
      compare("arready", 0, arready);  // Read path closed
    end
    rready = 1'b1;
    @(negedge clka);
    rready = 1'b0;
  endtask

  task automatic run_entry(input entry_t e);
    logic [31:0] data;
    data = e.rnd ? rand_word() : e.data;
    case (e.op)
      OP_WR: begin
        case (e.order)
          AW_THEN_W: begin
            aw_phase(e.addr);
            w_phase(data, e.strb);
          end
          W_THEN_AW: begin
            w_phase(data, e.strb);
            aw_phase(e.addr);
          end
          default: fork
            aw_phase(e.addr);
            w_phase(data, e.strb);
          join
        endcase
        update_model(e.addr, data, e.strb);  // Write issued
        b_response(e.hold, e.resp);
      end
      OP_RD: begin
        ar_phase(e.addr);
        r_response(e.hold, expected_word(e.addr), e.resp);
      end
      default: begin
        fork  // AW, W and AR in one cycle
          aw_phase(e.addr);
          w_phase(data, e.strb);
          ar_phase(e.addr);
        join
        update_model(e.addr, data, e.strb);  // Write lands before the read
        fork
          b_response(e.hold, e.resp);
          r_response(e.hold, expected_word(e.addr), e.resp);
        join
      end
    endcase
  endtask

  task automatic add_entry(input op_e op, input logic [31:0] addr, input logic [31:0] data,
                           input logic rnd, input logic [3:0] strb, input order_e order,
                           input logic [3:0] hold, input resp_e resp);
    rows[n_rows] = '{op, addr, data, rnd, strb, order, hold, resp};
    n_rows++;
  endtask

  // Watchdog, 40 cycles per row plus margin
  initial begin
    wait (rows_ready);
    #((n_rows * 40 + 100) * CLK_NS);
    $display("Timeout at %0d ns, a handshake never completed", $time);
    $display("Testbench failed");
    $fatal(1, "watchdog expired");
  end

  // Bound handshake assertions stop the run at their first failure
  initial begin
    wait (dut_i.chk_i.fail_cnt != 0);
    $display("Protocol assertion failed at %0d ns", $time);
    $display("Testbench failed");
    $fatal(1, "protocol check failed");
  end

  initial begin
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    for (int a = 0; a < LIMIT; a++) model[a] = '0;  // Store comes up cleared

    // Unwritten words, full writes and read-back on several lines
    add_entry(OP_RD,    32'h0000_0000, 32'h0,        0, 4'hf, AW_WITH_W, 0, RESP_OKAY);
    add_entry(OP_WR,    32'h0000_0000, 32'h0,        1, 4'hf, AW_THEN_W, 0, RESP_OKAY);
    add_entry(OP_RD,    32'h0000_0000, 32'h0,        0, 4'hf, AW_WITH_W, 0, RESP_OKAY);
    add_entry(OP_WR,    32'h0000_07c4, 32'h0,        1, 4'hf, W_THEN_AW, 0, RESP_OKAY);
    add_entry(OP_RD,    32'h0000_07c4, 32'h0,        0, 4'hf, AW_WITH_W, 0, RESP_OKAY);
    add_entry(OP_RD,    32'h0000_07c0, 32'h0,        0, 4'hf, AW_WITH_W, 0, RESP_OKAY);
    add_entry(OP_WR,    32'h0000_0ffc, 32'h0,        1, 4'hf, AW_WITH_W, 0, RESP_OKAY);
    add_entry(OP_RD,    32'h0000_0ffc, 32'h0,        0, 4'hf, AW_WITH_W, 0, RESP_OKAY);
    add_entry(OP_RD,    32'h0000_0104, 32'h0,        0, 4'hf, AW_WITH_W, 0, RESP_OKAY);
    // Partial strobes merge
    add_entry(OP_WR,    32'h0000_0040, 32'h11223344, 0, 4'hf, AW_THEN_W, 0, RESP_OKAY);
    add_entry(OP_WR,    32'h0000_0040, 32'haabbccdd, 0, 4'h5, W_THEN_AW, 0, RESP_OKAY);
    add_entry(OP_RD,    32'h0000_0040, 32'h0,        0, 4'hf, AW_WITH_W, 0, RESP_OKAY);
    add_entry(OP_WR,    32'h0000_0040, 32'h0,        1, 4'h8, AW_WITH_W, 0, RESP_OKAY);
    add_entry(OP_RD,    32'h0000_0040, 32'h0,        0, 4'hf, AW_WITH_W, 0, RESP_OKAY);
    // Same-line write and read, forwarded
    add_entry(OP_WR_RD, 32'h0000_0080, 32'h0,        1, 4'hf, AW_WITH_W, 0, RESP_OKAY);
    add_entry(OP_WR_RD, 32'h0000_0080, 32'h0,        1, 4'h3, AW_WITH_W, 0, RESP_OKAY);
    add_entry(OP_WR_RD, 32'h0000_00a4, 32'h0,        1, 4'h6, AW_WITH_W, 0, RESP_OKAY);
    // Out of range, 0x1000 aliases line 0 word 0
    add_entry(OP_WR,    32'h0000_1000, 32'hdeadbeef, 0, 4'hf, AW_WITH_W, 0, RESP_SLVERR);
    add_entry(OP_RD,    32'h0000_0000, 32'h0,        0, 4'hf, AW_WITH_W, 0, RESP_OKAY);
    add_entry(OP_RD,    32'h0000_1004, 32'h0,        0, 4'hf, AW_WITH_W, 0, RESP_SLVERR);
    add_entry(OP_RD,    32'hffff_fffc, 32'h0,        0, 4'hf, AW_WITH_W, 0, RESP_SLVERR);
    // Back-pressure on B and R
    add_entry(OP_WR,    32'h0000_02c8, 32'h0,        1, 4'hf, AW_THEN_W, 5, RESP_OKAY);
    add_entry(OP_RD,    32'h0000_02c8, 32'h0,        0, 4'hf, AW_WITH_W, 4, RESP_OKAY);
    add_entry(OP_WR_RD, 32'h0000_03f0, 32'h0,        1, 4'hf, AW_WITH_W, 3, RESP_OKAY);
    add_entry(OP_WR,    32'h0000_03f0, 32'h0,        1, 4'h6, W_THEN_AW, 2, RESP_OKAY);
    add_entry(OP_RD,    32'h0000_03f0, 32'h0,        0, 4'hf, AW_WITH_W, 0, RESP_OKAY);
    rows_ready = 1'b1;

    wait (rst_n);
    for (int i = 0; i < n_rows; i++) begin
      run_entry(rows[i]);
    end

    if (dut_i.chk_i.fail_cnt == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      $display("%0d protocol assertion failures reported", dut_i.chk_i.fail_cnt);
      $display("Testbench failed");
      $fatal(1, "protocol checks failed");
    end
  end

endmodule

/* list.f */
+incdir+rtl
rtl/clap_pkg.sv
rtl/req_slice.sv
rtl/cache_memory.sv
rtl/axil_req_decode.sv
rtl/line_result.sv
rtl/cache_line_store.sv
sim/tb_clock.sv
sim/cache_line_store_chk.sv
sim/cache_line_store_tb.sv

/* Bender.yml */
package:
  name: clap_cache_line_store

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/clap_pkg.sv
      - rtl/req_slice.sv
      - rtl/cache_memory.sv
      - rtl/axil_req_decode.sv
      - rtl/line_result.sv
      - rtl/cache_line_store.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/tb_clock.sv
      - sim/cache_line_store_chk.sv
      - sim/cache_line_store_tb.sv
